/* logic/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and PC width
`define MIPS_XLEN 32

// Architectural registers and the index width they need
`define MIPS_REG_COUNT 32
`define MIPS_REG_BITS $clog2(`MIPS_REG_COUNT)

// Cache word address width
`define MIPS_WADDR_BITS 30

`define MIPS_RESET_PC 32'h0000_0000

`endif

/* logic/mipsPkg.sv */
package mipsPkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    // All zero means bubble
    typedef struct packed {
        logic regDst;
        logic aluSrc;
        logic branch;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic spare;
    } ctrlWord_t;

endpackage

/* logic/pipeBuses.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

interface fetchDecodeBus;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] instruction;
    // Feedback from decode
    logic                  hold;
    logic                  jumpTaken;
    logic [`MIPS_XLEN-1:0] jumpTarget;

    modport fetch (output pcPlus4, instruction, input hold, jumpTaken, jumpTarget);
    modport decode (input pcPlus4, instruction, output hold, jumpTaken, jumpTarget);
endinterface

interface decodeExecuteBus;
    mipsPkg::ctrlWord_t        ctrl;
    mipsPkg::aluOp_t           aluOp;
    logic [`MIPS_XLEN-1:0]     readData1;
    logic [`MIPS_XLEN-1:0]     readData2;
    logic [`MIPS_XLEN-1:0]     imm;
    logic [`MIPS_XLEN-1:0]     pcPlus4;
    logic [`MIPS_REG_BITS-1:0] rs;
    logic [`MIPS_REG_BITS-1:0] rt;
    logic [`MIPS_REG_BITS-1:0] rd;

    modport producer (output ctrl, aluOp, readData1, readData2, imm, pcPlus4, rs, rt, rd);
    modport consumer (input ctrl, aluOp, readData1, readData2, imm, pcPlus4, rs, rt, rd);
endinterface

interface executeMemoryBus;
    mipsPkg::ctrlWord_t        ctrl;
    logic [`MIPS_XLEN-1:0]     aluResult;
    logic                      zero;
    logic [`MIPS_XLEN-1:0]     branchTarget;
    logic [`MIPS_XLEN-1:0]     storeData;
    // rt of a store, kept for late forwarding
    logic [`MIPS_REG_BITS-1:0] storeReg;
    logic [`MIPS_REG_BITS-1:0] writeReg;

    modport producer (
        output ctrl, aluResult, zero, branchTarget, storeData, storeReg, writeReg
    );
    modport consumer (
        input ctrl, aluResult, zero, branchTarget, storeData, storeReg, writeReg
    );
endinterface

/* logic/fetchStage.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module fetchStage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        freeze,
    input  logic                        branchTaken,
    input  logic [`MIPS_XLEN-1:0]       branchTarget,
    output logic [`MIPS_WADDR_BITS-1:0] icacheAddr,
    input  logic [`MIPS_XLEN-1:0]       icacheRdata,
    fetchDecodeBus.fetch                fd
);

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] nextPc;
    logic                  redirect;

    assign pcPlus4    = pc + 4;
    assign redirect   = branchTaken || fd.jumpTaken;
    assign icacheAddr = pc[`MIPS_XLEN-1 -: `MIPS_WADDR_BITS];

    // Branch from memory is older than a jump in decode, so it wins
    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else if (fd.jumpTaken) begin
            nextPc = fd.jumpTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else if (!freeze && (redirect || !fd.hold)) begin
            pc <= nextPc;
        end
    end

    // Fetch/decode register, cleared instruction decodes as a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fd.instruction <= '0;
        end else if (!freeze) begin
            if (redirect) begin
                fd.instruction <= '0;
            end else if (!fd.hold) begin
                fd.instruction <= icacheRdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !fd.hold) begin
            fd.pcPlus4 <= pcPlus4;
        end
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module registerFile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`MIPS_REG_BITS-1:0] readReg1,
    input  logic [`MIPS_REG_BITS-1:0] readReg2,
    input  logic                      writeEnable,
    input  logic [`MIPS_REG_BITS-1:0] writeReg,
    input  logic [`MIPS_XLEN-1:0]     writeData,
    output logic [`MIPS_XLEN-1:0]     readData1,
    output logic [`MIPS_XLEN-1:0]     readData2
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];
    logic                  writeValid;

    // Register zero is never written so it keeps its reset value
    assign writeValid = writeEnable && (writeReg != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeValid) begin
            regs[writeReg] <= writeData;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign readData1 = (writeValid && writeReg == readReg1) ? writeData : regs[readReg1];
    assign readData2 = (writeValid && writeReg == readReg2) ? writeData : regs[readReg2];

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module decodeStage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      freeze,
    input  logic                      branchTaken,
    fetchDecodeBus.decode             fd,
    decodeExecuteBus.producer         de,
    input  logic                      wbRegWrite,
    input  logic [`MIPS_REG_BITS-1:0] wbWriteReg,
    input  logic [`MIPS_XLEN-1:0]     wbWriteData
);

    mipsPkg::opcode_t          opcode;
    mipsPkg::funct_t           funct;
    mipsPkg::ctrlWord_t        ctrl;
    mipsPkg::aluOp_t           aluOp;
    logic [`MIPS_REG_BITS-1:0] rs;
    logic [`MIPS_REG_BITS-1:0] rt;
    logic [`MIPS_REG_BITS-1:0] rd;
    logic [`MIPS_XLEN-1:0]     imm;
    logic [`MIPS_XLEN-1:0]     readData1;
    logic [`MIPS_XLEN-1:0]     readData2;
    logic                      isJump;
    logic                      usesRs;
    logic                      usesRt;
    logic                      loadUse;

    assign opcode = mipsPkg::opcode_t'(fd.instruction[31:26]);
    assign funct  = mipsPkg::funct_t'(fd.instruction[5:0]);
    assign rs     = fd.instruction[25:21];
    assign rt     = fd.instruction[20:16];
    assign rd     = fd.instruction[15:11];
    assign imm    = {{(`MIPS_XLEN-16){fd.instruction[15]}}, fd.instruction[15:0]};

    // Jump resolves here
    assign fd.jumpTaken  = isJump;
    assign fd.jumpTarget = {fd.pcPlus4[`MIPS_XLEN-1 -: 4], fd.instruction[25:0], 2'b00};

    always_comb begin
        ctrl   = '0;
        aluOp  = mipsPkg::aluAdd;
        isJump = 1'b0;
        usesRs = 1'b0;
        usesRt = 1'b0;
        case (opcode)
            mipsPkg::opRType: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                usesRs        = 1'b1;
                usesRt        = 1'b1;
                case (funct)
                    mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
                    mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
                    default: begin
                        ctrl   = '0;
                        usesRs = 1'b0;
                        usesRt = 1'b0;
                    end
                endcase
            end
            mipsPkg::opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                usesRs        = 1'b1;
            end
            mipsPkg::opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                usesRs        = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                usesRs        = 1'b1;
                usesRt        = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.branch = 1'b1;
                aluOp       = mipsPkg::aluSub;
                usesRs      = 1'b1;
                usesRt      = 1'b1;
            end
            mipsPkg::opJ: begin
                isJump = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // Load in execute feeding this instruction needs one bubble
    assign loadUse = de.ctrl.memRead &&
                     ((usesRs && rs == de.rt) || (usesRt && rt == de.rt));
    assign fd.hold = loadUse;

    registerFile regFile (
        .clk         (clk),
        .rst_n       (rst_n),
        .readReg1    (rs),
        .readReg2    (rt),
        .writeEnable (wbRegWrite && !freeze),
        .writeReg    (wbWriteReg),
        .writeData   (wbWriteData),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de.ctrl <= '0;
        end else if (!freeze) begin
            if (branchTaken || loadUse) begin
                de.ctrl <= '0;
            end else begin
                de.ctrl <= ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            de.aluOp     <= aluOp;
            de.readData1 <= readData1;
            de.readData2 <= readData2;
            de.imm       <= imm;
            de.pcPlus4   <= fd.pcPlus4;
            de.rs        <= rs;
            de.rt        <= rt;
            de.rd        <= rd;
        end
    end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module executeStage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      freeze,
    input  logic                      branchTaken,
    decodeExecuteBus.consumer         de,
    executeMemoryBus.producer         em,
    input  logic                      wbRegWrite,
    input  logic [`MIPS_REG_BITS-1:0] wbWriteReg,
    input  logic [`MIPS_XLEN-1:0]     wbWriteData
);

    logic [`MIPS_XLEN-1:0]     srcA;
    logic [`MIPS_XLEN-1:0]     srcB;
    logic [`MIPS_XLEN-1:0]     opB;
    logic [`MIPS_XLEN-1:0]     aluResult;
    logic [`MIPS_XLEN-1:0]     branchTarget;
    logic                      zero;
    logic [`MIPS_REG_BITS-1:0] destReg;

    // Newest producer first: memory stage, then writeback
    function automatic logic [`MIPS_XLEN-1:0] forward(
        input logic [`MIPS_REG_BITS-1:0] src,
        input logic [`MIPS_XLEN-1:0]     regValue
    );
        if (em.ctrl.regWrite && em.writeReg != '0 && em.writeReg == src) begin
            return em.aluResult;
        end else if (wbRegWrite && wbWriteReg != '0 && wbWriteReg == src) begin
            return wbWriteData;
        end
        return regValue;
    endfunction

    always_comb begin
        srcA = forward(de.rs, de.readData1);
        srcB = forward(de.rt, de.readData2);
    end

    assign opB = de.ctrl.aluSrc ? de.imm : srcB;

    always_comb begin
        case (de.aluOp)
            mipsPkg::aluAdd: aluResult = srcA + opB;
            mipsPkg::aluSub: aluResult = srcA - opB;
            mipsPkg::aluAnd: aluResult = srcA & opB;
            mipsPkg::aluOr:  aluResult = srcA | opB;
            mipsPkg::aluSlt: aluResult = {{(`MIPS_XLEN-1){1'b0}}, $signed(srcA) < $signed(opB)};
            default:         aluResult = '0;
        endcase
    end

    assign zero         = (aluResult == '0);
    assign branchTarget = de.pcPlus4 + {de.imm[`MIPS_XLEN-3:0], 2'b00};
    assign destReg      = de.ctrl.regDst ? de.rd : de.rt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            em.ctrl <= '0;
        end else if (!freeze) begin
            if (branchTaken) begin
                em.ctrl <= '0;
            end else begin
                em.ctrl <= de.ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            em.aluResult    <= aluResult;
            em.zero         <= zero;
            em.branchTarget <= branchTarget;
            em.storeData    <= srcB;
            em.storeReg     <= de.rt;
            em.writeReg     <= destReg;
        end
    end

endmodule

/* logic/memoryStage.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module memoryStage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        freeze,
    executeMemoryBus.consumer           em,
    output logic                        dcacheRen,
    output logic                        dcacheWen,
    output logic [`MIPS_WADDR_BITS-1:0] dcacheAddr,
    output logic [`MIPS_XLEN-1:0]       dcacheWdata,
    input  logic [`MIPS_XLEN-1:0]       dcacheRdata,
    output logic                        branchTaken,
    output logic [`MIPS_XLEN-1:0]       branchTarget,
    output logic                        regWrite,
    output logic [`MIPS_REG_BITS-1:0]   writeReg,
    output logic [`MIPS_XLEN-1:0]       writeData
);

    logic                  memToReg;
    logic [`MIPS_XLEN-1:0] loadData;
    logic [`MIPS_XLEN-1:0] aluResult;
    logic                  storeFwd;

    assign branchTaken  = em.ctrl.branch && em.zero;
    assign branchTarget = em.branchTarget;

    assign dcacheRen  = em.ctrl.memRead;
    assign dcacheWen  = em.ctrl.memWrite;
    assign dcacheAddr = em.aluResult[`MIPS_XLEN-1 -: `MIPS_WADDR_BITS];

    // Store rt still being retired by the instruction just ahead
    assign storeFwd    = regWrite && writeReg != '0 && writeReg == em.storeReg;
    assign dcacheWdata = storeFwd ? writeData : em.storeData;

    // A taken branch leaves as a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regWrite <= 1'b0;
            memToReg <= 1'b0;
        end else if (!freeze) begin
            regWrite <= em.ctrl.regWrite && !branchTaken;
            memToReg <= em.ctrl.memToReg && !branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            writeReg  <= em.writeReg;
            loadData  <= dcacheRdata;
            aluResult <= em.aluResult;
        end
    end

    assign writeData = memToReg ? loadData : aluResult;

endmodule

/* logic/mipsPipeline.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module mipsPipeline (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [`MIPS_WADDR_BITS-1:0] icacheAddr,
    input  logic [`MIPS_XLEN-1:0]       icacheRdata,
    input  logic                        icacheStall,
    output logic                        dcacheRen,
    output logic                        dcacheWen,
    output logic [`MIPS_WADDR_BITS-1:0] dcacheAddr,
    output logic [`MIPS_XLEN-1:0]       dcacheWdata,
    input  logic [`MIPS_XLEN-1:0]       dcacheRdata,
    input  logic                        dcacheStall
);

    logic                      freeze;
    logic                      branchTaken;
    logic [`MIPS_XLEN-1:0]     branchTarget;
    logic                      wbRegWrite;
    logic [`MIPS_REG_BITS-1:0] wbWriteReg;
    logic [`MIPS_XLEN-1:0]     wbWriteData;

    fetchDecodeBus   fdBus ();
    decodeExecuteBus deBus ();
    executeMemoryBus emBus ();

    // Either cache stalling holds the whole pipe
    assign freeze = icacheStall || dcacheStall;

    fetchStage fetchUnit (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeze       (freeze),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .icacheAddr   (icacheAddr),
        .icacheRdata  (icacheRdata),
        .fd           (fdBus)
    );

    decodeStage decodeUnit (
        .clk         (clk),
        .rst_n       (rst_n),
        .freeze      (freeze),
        .branchTaken (branchTaken),
        .fd          (fdBus),
        .de          (deBus),
        .wbRegWrite  (wbRegWrite),
        .wbWriteReg  (wbWriteReg),
        .wbWriteData (wbWriteData)
    );

    executeStage executeUnit (
        .clk         (clk),
        .rst_n       (rst_n),
        .freeze      (freeze),
        .branchTaken (branchTaken),
        .de          (deBus),
        .em          (emBus),
        .wbRegWrite  (wbRegWrite),
        .wbWriteReg  (wbWriteReg),
        .wbWriteData (wbWriteData)
    );

    // Memory access and writeback result
    memoryStage memoryUnit (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeze       (freeze),
        .em           (emBus),
        .dcacheRen    (dcacheRen),
        .dcacheWen    (dcacheWen),
        .dcacheAddr   (dcacheAddr),
        .dcacheWdata  (dcacheWdata),
        .dcacheRdata  (dcacheRdata),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .regWrite     (wbRegWrite),
        .writeReg     (wbWriteReg),
        .writeData    (wbWriteData)
    );

endmodule

/* bench/mipsPipelineTb.sv */
`timescale 1ns/100ps
`include "mips_settings.svh"

module mipsPipelineTb;

    localparam int progWords   = 64;
    localparam int dataWords   = 256;
    localparam int resetCycles = 16;
    localparam int drainCycles = 20;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic [`MIPS_WADDR_BITS-1:0] icacheAddr;
    logic [`MIPS_XLEN-1:0]       icacheRdata;
    logic                        icacheStall;
    logic                        dcacheRen;
    logic                        dcacheWen;
    logic [`MIPS_WADDR_BITS-1:0] dcacheAddr;
    logic [`MIPS_XLEN-1:0]       dcacheWdata;
    logic [`MIPS_XLEN-1:0]       dcacheRdata;
    logic                        dcacheStall;

    logic [31:0] prog [progWords];
    logic [31:0] dataMem [dataWords];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [29:0] endWord;
    logic [31:0] lfsr = 32'hc7b7_a2ff;
    logic [3:0]  stallBits;
    logic        iStallNext;
    logic        stallsOn;
    int          storeIdx;
    int          cycleCount;
    int          cycleLimit;

    mipsPipeline UUT (.*);

    always #2 clk = ~clk;

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] fillWord(input int index);
        return 32'h5a5a_0000 + index * 32'h0001_0101;
    endfunction

    function automatic logic [31:0] rInst(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input mipsPkg::funct_t fn);
        return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iInst(input mipsPkg::opcode_t op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jInst(input logic [25:0] index);
        return {mipsPkg::opJ, index};
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < progWords; i++) begin
            prog[i] = '0;
        end
        // Dependent ALU chain, r0 write, then the stores
        prog[0]  = iInst(mipsPkg::opAddi, 5'd0, 5'd1, 16'd25);
        prog[1]  = iInst(mipsPkg::opAddi, 5'd0, 5'd2, -16'sd7);
        prog[2]  = rInst(5'd1, 5'd2, 5'd3, mipsPkg::fnAdd);
        prog[3]  = rInst(5'd3, 5'd1, 5'd4, mipsPkg::fnSub);
        prog[4]  = rInst(5'd4, 5'd3, 5'd5, mipsPkg::fnAnd);
        prog[5]  = rInst(5'd5, 5'd2, 5'd6, mipsPkg::fnOr);
        prog[6]  = rInst(5'd4, 5'd3, 5'd7, mipsPkg::fnSlt);
        prog[7]  = rInst(5'd3, 5'd4, 5'd8, mipsPkg::fnSlt);
        prog[8]  = iInst(mipsPkg::opAddi, 5'd3, 5'd0, 16'd99);
        prog[9]  = iInst(mipsPkg::opSw, 5'd0, 5'd0, 16'h0118);
        prog[10] = iInst(mipsPkg::opSw, 5'd0, 5'd3, 16'h0100);
        prog[11] = iInst(mipsPkg::opSw, 5'd0, 5'd4, 16'h0104);
        prog[12] = iInst(mipsPkg::opSw, 5'd0, 5'd5, 16'h0108);
        prog[13] = iInst(mipsPkg::opSw, 5'd0, 5'd6, 16'h010c);
        prog[14] = iInst(mipsPkg::opSw, 5'd0, 5'd7, 16'h0110);
        prog[15] = iInst(mipsPkg::opSw, 5'd0, 5'd8, 16'h0114);
        // Load-use into an add and into a store
        prog[16] = iInst(mipsPkg::opLw, 5'd0, 5'd10, 16'h0040);
        prog[17] = rInst(5'd10, 5'd1, 5'd11, mipsPkg::fnAdd);
        prog[18] = iInst(mipsPkg::opSw, 5'd0, 5'd11, 16'h011c);
        prog[19] = iInst(mipsPkg::opLw, 5'd0, 5'd12, 16'h0044);
        prog[20] = iInst(mipsPkg::opSw, 5'd0, 5'd12, 16'h0120);
        // Branch not taken, then taken over three stores
        prog[21] = iInst(mipsPkg::opBeq, 5'd1, 5'd2, 16'd3);
        prog[22] = iInst(mipsPkg::opSw, 5'd0, 5'd1, 16'h0124);
        prog[23] = iInst(mipsPkg::opAddi, 5'd0, 5'd15, 16'd25);
        prog[24] = iInst(mipsPkg::opBeq, 5'd15, 5'd1, 16'd3);
        prog[25] = iInst(mipsPkg::opSw, 5'd0, 5'd2, 16'h0128);
        prog[26] = iInst(mipsPkg::opSw, 5'd0, 5'd3, 16'h012c);
        prog[27] = iInst(mipsPkg::opSw, 5'd0, 5'd4, 16'h0130);
        prog[28] = iInst(mipsPkg::opSw, 5'd0, 5'd15, 16'h0134);
        prog[29] = jInst(26'd31);
        prog[30] = iInst(mipsPkg::opSw, 5'd0, 5'd1, 16'h0138);
        prog[31] = iInst(mipsPkg::opSw, 5'd0, 5'd2, 16'h013c);
        prog[32] = jInst(26'd32);
    endtask

    // Architectural model without delay slots that returns the instruction count
    function automatic int interpretProgram();
        logic [31:0] regs [32];
        logic [31:0] mem [dataWords];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dataWords; i++) begin
            mem[i] = fillWord(i);
        end
        expAddr.delete();
        expData.delete();
        pc = `MIPS_RESET_PC;
        inst = prog[pc[7:2]];
        steps = 0;
        // A jump to itself ends the program
        while (inst != jInst(pc[27:2]) && steps < 1000) begin
            a = regs[inst[25:21]];
            b = regs[inst[20:16]];
            imm = {{16{inst[15]}}, inst[15:0]};
            addr = a + imm;
            nextPc = pc + 4;
            case (inst[31:26])
                mipsPkg::opRType: begin
                    case (inst[5:0])
                        mipsPkg::fnAdd: regs[inst[15:11]] = a + b;
                        mipsPkg::fnSub: regs[inst[15:11]] = a - b;
                        mipsPkg::fnAnd: regs[inst[15:11]] = a & b;
                        mipsPkg::fnOr:  regs[inst[15:11]] = a | b;
                        mipsPkg::fnSlt: regs[inst[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: ;
                    endcase
                end
                mipsPkg::opAddi: regs[inst[20:16]] = addr;
                mipsPkg::opLw:   regs[inst[20:16]] = mem[addr[9:2]];
                mipsPkg::opSw: begin
                    mem[addr[9:2]] = b;
                    expAddr.push_back({2'b00, addr[31:2]});
                    expData.push_back(b);
                end
                mipsPkg::opBeq: begin
                    if (a == b) begin
                        nextPc = pc + 4 + {imm[29:0], 2'b00};
                    end
                end
                mipsPkg::opJ: nextPc = {nextPc[31:28], inst[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = '0;
            pc = nextPc;
            inst = prog[pc[7:2]];
            steps++;
        end
        endWord = pc[31:2];
        return steps;
    endfunction

    // Cache models answer on the falling edge
    always @(negedge clk) begin
        icacheRdata <= (icacheAddr < progWords) ? prog[icacheAddr] : '0;
        dcacheRdata <= dcacheRen ? dataMem[dcacheAddr[7:0]] : 'x;
        if (stallsOn) begin
            for (int k = 0; k < 4; k++) begin
                lfsr = lfsrNext(lfsr);
                stallBits[k] = lfsr[0];
            end
            iStallNext = stallBits[0] && stallBits[1];
            icacheStall <= iStallNext;
            // Shared refill port, so an instruction miss holds the data cache too
            dcacheStall <= iStallNext || (stallBits[2] && stallBits[3]);
        end else begin
            icacheStall <= 1'b0;
            dcacheStall <= 1'b0;
        end
    end

    // Store checker and data cache write
    always @(posedge clk) begin
        if (dcacheWen === 1'b1 && dcacheStall === 1'b0) begin
            if (storeIdx >= expAddr.size()) begin
                reportFailure("A store appeared beyond the end of the expected store list");
            end else begin
                checkValue($sformatf("store %0d address", storeIdx), expAddr[storeIdx],
                           {2'b00, dcacheAddr});
                checkValue($sformatf("store %0d data", storeIdx), expData[storeIdx],
                           dcacheWdata);
                dataMem[dcacheAddr[7:0]] = dcacheWdata;
                storeIdx++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            reportFailure("Timeout, the program did not reach its end within the cycle limit");
        end
    end

    task automatic runProgram(input logic withStalls, input string runName);
        int steps;
        int expCount;
        int drained;
        stallsOn <= withStalls;
        rst_n    <= 1'b0;
        steps = interpretProgram();
        expCount = expAddr.size();
        for (int i = 0; i < dataWords; i++) begin
            dataMem[i] = fillWord(i);
        end
        storeIdx   = 0;
        cycleCount = 0;
        cycleLimit = steps * 6 + resetCycles + 100;
        // Last sample also holds through the first cycle with rst_n high
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
            checkValue({runName, " reset dcacheRen"}, '0, dcacheRen);
            checkValue({runName, " reset dcacheWen"}, '0, dcacheWen);
            checkValue({runName, " reset icacheAddr"}, (`MIPS_RESET_PC) >> 2, icacheAddr);
        end
        rst_n <= 1'b1;
        // Fetch of the closing self-jump marks the end of the program
        while (icacheAddr != endWord) begin
            @(negedge clk);
        end
        drained = 0;
        while (drained < drainCycles) begin
            @(negedge clk);
            if (!icacheStall && !dcacheStall) begin
                drained++;
            end
        end
        if (storeIdx != expCount) begin
            reportFailure($sformatf("%s finished with %0d stores instead of %0d",
                                    runName, storeIdx, expCount));
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        icacheRdata = '0;
        dcacheRdata = '0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        stallsOn    = 1'b0;
        storeIdx    = 0;
        cycleCount  = 0;
        cycleLimit  = 1000;
        loadProgram();
        runProgram(1'b0, "clean run");
        runProgram(1'b1, "stall run");
        $display("Testbench passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/mipsPkg.sv
logic/pipeBuses.sv
logic/fetchStage.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsPipeline.sv
bench/mipsPipelineTb.sv
